// File: Makefile
TOP = camera_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

obj_dir/V$(TOP): sim.f hw/*.sv hw/*.svh tests/*.sv
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q ">>> PASS" $(LOG) || { echo "simulation ended without a verdict"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

// File: hw/cam_macros.svh
`ifndef CAM_MACROS_SVH
`define CAM_MACROS_SVH

// sensor channels presented each sample period
`define CAM_CHANNELS 4

// frame geometry in packed words
`define CAM_LINE_WORDS 8
`define CAM_FRAME_LINES 4

// line buffer entries, also the credits held by capture after reset
// power of two, the buffer pointers wrap on it
`define CAM_FIFO_DEPTH 8

// idle cycles on the output after every line
`define CAM_HBLANK 3

`endif

// File: hw/cam_pkg.sv
package cam_pkg;

    // raw sensor sample
    typedef logic [9:0] sample_t;

    // windowed pixel
    typedef logic [7:0] pix_byte_t;

    // four pixels, channel 0 in the low byte
    typedef logic [31:0] pix_word_t;

    // window select
    // 0 takes bits 9:2, 1 takes 8:1, 2 and 3 take 7:0
    typedef logic [1:0] gain_t;

    // credit count, must reach the full buffer depth
    typedef logic [3:0] credit_t;

    // output formatter states
    typedef enum logic [1:0] {
        FMT_IDLE,
        FMT_LINE,
        FMT_BLANK
    } fmt_state_t;

endpackage

// File: hw/camera_core.sv
`include "cam_macros.svh"

module camera_core
    import cam_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      sensor_valid,
    input  sample_t   samples [`CAM_CHANNELS],
    input  gain_t     gain,
    input  logic      out_ready,
    output logic      sensor_ready,
    output logic      out_valid,
    output pix_word_t out_data,
    output logic      lval,
    output logic      fval
);

    // capture to buffer, credits flow back
    pix_stream_if cap_to_buf ();

    // buffer head to formatter, credit used as the pop request
    pix_stream_if buf_to_fmt ();

    pixel_capture i_pixel_capture (
        .clk          (clk),
        .rst_n        (rst_n),
        .sensor_valid (sensor_valid),
        .samples      (samples),
        .gain         (gain),
        .sensor_ready (sensor_ready),
        .tx           (cap_to_buf.sender)
    );

    line_buffer i_line_buffer (
        .clk   (clk),
        .rst_n (rst_n),
        .rx    (cap_to_buf.receiver),
        .tx    (buf_to_fmt.sender)
    );

    video_formatter i_video_formatter (
        .clk       (clk),
        .rst_n     (rst_n),
        .out_ready (out_ready),
        .rx        (buf_to_fmt.receiver),
        .out_valid (out_valid),
        .out_data  (out_data),
        .lval      (lval),
        .fval      (fval)
    );

endmodule

// File: hw/line_buffer.sv
`include "cam_macros.svh"

module line_buffer
    import cam_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    pix_stream_if.receiver rx,
    pix_stream_if.sender   tx
);

    localparam int AW = $clog2(`CAM_FIFO_DEPTH);

    // pointers carry one wrap bit above the index
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        empty;
    logic        pop;
    logic [2:0]  head_marks;

    pix_word_t   word_mem [`CAM_FIFO_DEPTH];
    // {sof, eol, eof} per entry
    logic [2:0]  mark_mem [`CAM_FIFO_DEPTH];

    assign empty = (wr_ptr == rd_ptr);

    // downstream credit is the formatter asking for the head
    assign pop = tx.credit && !empty;

    // no full check here, the capture credits keep pushes within depth
    always_ff @(posedge clk)
    begin
        if (rx.push)
        begin
            word_mem[wr_ptr[AW-1:0]] <= rx.word;
            mark_mem[wr_ptr[AW-1:0]] <= {rx.sof, rx.eol, rx.eof};
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (rx.push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    assign head_marks = mark_mem[rd_ptr[AW-1:0]];

    // push downstream means the head entry is valid
    assign tx.push = !empty;
    assign tx.word = word_mem[rd_ptr[AW-1:0]];
    assign tx.sof  = head_marks[2];
    assign tx.eol  = head_marks[1];
    assign tx.eof  = head_marks[0];

    // every pop frees one entry, hand it back to capture
    assign rx.credit = pop;

endmodule

// File: hw/pix_stream_if.sv
interface pix_stream_if
    import cam_pkg::*;
();

    // one pulse per word
    logic      push;
    pix_word_t word;

    // frame and line marks travelling with the word
    logic      sof;
    logic      eol;
    logic      eof;

    // flows back against the words, one pulse per credit
    logic      credit;

    modport sender (
        output push,
        output word,
        output sof,
        output eol,
        output eof,
        input  credit
    );

    modport receiver (
        input  push,
        input  word,
        input  sof,
        input  eol,
        input  eof,
        output credit
    );

endinterface

// File: hw/pixel_capture.sv
`include "cam_macros.svh"

module pixel_capture
    import cam_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         sensor_valid,
    input  sample_t      samples [`CAM_CHANNELS],
    input  gain_t        gain,
    output logic         sensor_ready,
    pix_stream_if.sender tx
);

    localparam int COL_W = $clog2(`CAM_LINE_WORDS);
    localparam int ROW_W = $clog2(`CAM_FRAME_LINES);
    localparam int BYTE_W = $bits(pix_byte_t);

    // a credit is spent when the set is accepted, the push follows a cycle later
    credit_t          credits;
    logic             accept;
    pix_word_t        next_word;
    logic [COL_W-1:0] col_q;
    logic [ROW_W-1:0] row_q;
    logic             last_col;
    logic             last_row;

    logic             push_q;
    pix_word_t        word_q;
    logic             sof_q;
    logic             eol_q;
    logic             eof_q;

    function automatic pix_byte_t gain_window(sample_t s, gain_t g);
        pix_byte_t b;
        case (g)
            2'd0:    b = s[9:2];
            2'd1:    b = s[8:1];
            default: b = s[7:0];
        endcase
        return b;
    endfunction

    assign sensor_ready = (credits != '0);
    assign accept       = sensor_valid && sensor_ready;

    always_comb
    begin
        next_word = '0;
        for (int i = 0; i < `CAM_CHANNELS; i++)
        begin
            next_word[i*BYTE_W +: BYTE_W] = gain_window(samples[i], gain);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            credits <= credit_t'(`CAM_FIFO_DEPTH);
        end
        else
        begin
            credits <= credits + credit_t'(tx.credit) - credit_t'(accept);
        end
    end

    assign last_col = (col_q == COL_W'(`CAM_LINE_WORDS - 1));
    assign last_row = (row_q == ROW_W'(`CAM_FRAME_LINES - 1));

    // column and row position of the next accepted set
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            col_q <= '0;
            row_q <= '0;
        end
        else if (accept)
        begin
            if (last_col)
            begin
                col_q <= '0;
                row_q <= last_row ? '0 : row_q + 1'b1;
            end
            else
            begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            push_q <= 1'b0;
        end
        else
        begin
            push_q <= accept;
        end
    end

    // word and marks, only looked at while push_q is high
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            word_q <= next_word;
            sof_q  <= (col_q == '0) && (row_q == '0);
            eol_q  <= last_col;
            eof_q  <= last_col && last_row;
        end
    end

    assign tx.push = push_q;
    assign tx.word = word_q;
    assign tx.sof  = sof_q;
    assign tx.eol  = eol_q;
    assign tx.eof  = eof_q;

endmodule

// File: hw/video_formatter.sv
`include "cam_macros.svh"

module video_formatter
    import cam_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           out_ready,
    pix_stream_if.receiver rx,
    output logic           out_valid,
    output pix_word_t      out_data,
    output logic           lval,
    output logic           fval
);

    localparam int BW = $clog2(`CAM_HBLANK + 1);

    fmt_state_t    state;
    logic [BW-1:0] blank_cnt;
    logic          cur_eol;
    logic          cur_eof;
    logic          xfer;
    logic          can_take;
    logic          in_gap;
    logic          pop;

    assign xfer = out_valid && out_ready;

    // register is free, or leaving now and not the end of a line
    assign can_take = !out_valid || (out_ready && !cur_eol);

    // last blank cycle may already pop, so the word lands right after the gap
    assign in_gap = (state == FMT_BLANK) && (blank_cnt != '0);

    assign pop = rx.push && can_take && !in_gap;

    // pop request goes back to the buffer
    assign rx.credit = pop;

    assign lval = (state == FMT_LINE);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state     <= FMT_IDLE;
            blank_cnt <= '0;
            out_valid <= 1'b0;
            fval      <= 1'b0;
        end
        else
        begin
            if (pop)
            begin
                out_valid <= 1'b1;
            end
            else if (xfer)
            begin
                out_valid <= 1'b0;
            end

            // high from the sof word until the eof word has gone
            if (pop && rx.sof)
            begin
                fval <= 1'b1;
            end
            else if (xfer && cur_eof)
            begin
                fval <= 1'b0;
            end

            case (state)
                FMT_IDLE:
                begin
                    if (pop)
                    begin
                        state <= FMT_LINE;
                    end
                end
                FMT_LINE:
                begin
                    if (xfer && cur_eol)
                    begin
                        state     <= FMT_BLANK;
                        blank_cnt <= BW'(`CAM_HBLANK - 1);
                    end
                end
                FMT_BLANK:
                begin
                    if (blank_cnt != '0)
                    begin
                        blank_cnt <= blank_cnt - 1'b1;
                    end
                    else
                    begin
                        state <= pop ? FMT_LINE : FMT_IDLE;
                    end
                end
                default:
                begin
                    state <= FMT_IDLE;
                end
            endcase
        end
    end

    // output word and its marks
    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            out_data <= rx.word;
            cur_eol  <= rx.eol;
            cur_eof  <= rx.eof;
        end
    end

endmodule

// File: sim.f
+incdir+hw
hw/cam_pkg.sv
hw/pix_stream_if.sv
hw/pixel_capture.sv
hw/line_buffer.sv
hw/video_formatter.sv
hw/camera_core.sv
tests/camera_asserts.sv
tests/camera_tb.sv

// File: tests/camera_asserts.sv
`include "cam_macros.svh"

module camera_asserts
    import cam_pkg::*;
(
    input logic                              clk,
    input logic                              rst_n,
    input credit_t                           credits,
    input logic                              push,
    input logic [$clog2(`CAM_FIFO_DEPTH):0]  wr_ptr,
    input logic [$clog2(`CAM_FIFO_DEPTH):0]  rd_ptr,
    input logic                              out_valid,
    input logic                              out_ready,
    input pix_word_t                         out_data,
    input logic                              lval,
    input logic                              fval
);

    timeunit 1ns;
    timeprecision 1ps;

    // entries held in the line buffer
    logic [$clog2(`CAM_FIFO_DEPTH):0] fill;

    assign fill = wr_ptr - rd_ptr;

    // credits only come back for entries that were filled
    credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= credit_t'(`CAM_FIFO_DEPTH))
        else $error("credit count above the buffer depth");

    // every push was paid for, so it always finds a free entry
    push_with_credit: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> fill < `CAM_FIFO_DEPTH)
        else $error("push into a full line buffer");

    output_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("output word changed while stalled");

    // a word on the output always sits inside a line and a frame
    output_marks: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> lval && fval)
        else $error("output word outside lval or fval");

endmodule

// File: tests/camera_tb.sv
`include "cam_macros.svh"

module camera_tb
    import cam_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_WORDS = `CAM_LINE_WORDS * `CAM_FRAME_LINES;
    localparam int MAX_RECS = 64;
    localparam int STRICT_FRAMES = 2;
    localparam int RANDOM_FRAMES = 2;
    // the stall test sends one more frame
    localparam int SETS_TOTAL = (STRICT_FRAMES + RANDOM_FRAMES + 1) * FRAME_WORDS;
    localparam int WATCHDOG_CYCLES = SETS_TOTAL * 20 + 200;

    typedef enum {READY_HIGH, READY_LOW, READY_RANDOM} ready_mode_t;

    logic        clk;
    logic        rst_n;
    logic        sensor_valid;
    sample_t     samples [`CAM_CHANNELS];
    gain_t       gain;
    logic        out_ready;
    logic        sensor_ready;
    logic        out_valid;
    pix_word_t   out_data;
    logic        lval;
    logic        fval;

    gain_t       rec_gain [MAX_RECS];
    sample_t     rec_samples [MAX_RECS][`CAM_CHANNELS];
    pix_word_t   rec_word [MAX_RECS];
    int          nrec;
    int          next_rec;

    pix_word_t   exp_q [$];
    ready_mode_t ready_mode;
    bit          strict_gap;
    int          seed;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          test_errors0;
    int          test_rx0;
    int          rx_count;
    int          frame_pos;
    bit          after_eol;
    int          gap_cnt;

    camera_core i_camera_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .sensor_valid (sensor_valid),
        .samples      (samples),
        .gain         (gain),
        .out_ready    (out_ready),
        .sensor_ready (sensor_ready),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .lval         (lval),
        .fval         (fval)
    );

    bind camera_core camera_asserts i_camera_asserts (
        .clk       (clk),
        .rst_n     (rst_n),
        .credits   (i_pixel_capture.credits),
        .push      (cap_to_buf.push),
        .wr_ptr    (i_line_buffer.wr_ptr),
        .rd_ptr    (i_line_buffer.rd_ptr),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .lval      (lval),
        .fval      (fval)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t ns", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        errors++;
    endtask

    // gain 0 drops two low bits, gain 1 drops one, gains 2 and 3 keep the low byte
    function automatic pix_byte_t window_ref(sample_t s, gain_t g);
        int shift;
        shift = (g > 2'd1) ? 0 : 2 - int'(g);
        return pix_byte_t'(s >> shift);
    endfunction

    function automatic pix_word_t pack_ref(int r);
        pix_word_t w;
        w = '0;
        for (int c = 0; c < `CAM_CHANNELS; c++)
        begin
            w[c*8 +: 8] = window_ref(rec_samples[r][c], rec_gain[r]);
        end
        return w;
    endfunction

    task automatic load_records();
        int          fd;
        int          n;
        string       line;
        logic [31:0] v [6];
        logic [3:0]  gains_seen;
        nrec = 0;
        gains_seen = '0;
        fd = $fopen("tests/camera_tests.txt", "r");
        if (fd != 0)
        begin
            while (!$feof(fd) && nrec < MAX_RECS)
            begin
                line = "";
                n = $fgets(line, fd);
                // comment and empty lines yield no fields
                n = $sscanf(line, "%h %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4], v[5]);
                if (n == 6)
                begin
                    rec_gain[nrec] = gain_t'(v[0]);
                    for (int c = 0; c < `CAM_CHANNELS; c++)
                    begin
                        rec_samples[nrec][c] = sample_t'(v[c+1]);
                    end
                    rec_word[nrec] = v[5];
                    check_value("expected word in file", v[5], pack_ref(nrec));
                    gains_seen[rec_gain[nrec]] = 1'b1;
                    nrec++;
                end
            end
            $fclose(fd);
            if (gains_seen != 4'hf)
            begin
                report_error("the records do not cover all four gain values");
            end
        end
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send_set();
        sensor_valid = 1'b1;
        gain = rec_gain[next_rec];
        for (int c = 0; c < `CAM_CHANNELS; c++)
        begin
            samples[c] = rec_samples[next_rec][c];
        end
        while (!sensor_ready) @(negedge clk);
        exp_q.push_back(rec_word[next_rec]);
        next_rec = (next_rec + 1) % nrec;
        @(negedge clk);
        sensor_valid = 1'b0;
    endtask

    task automatic send_frames(input int frames);
        repeat (frames * FRAME_WORDS) send_set();
    endtask

    // mode changes on a rising edge, away from the receiver
    task automatic set_ready_mode(input ready_mode_t m, input bit strict);
        @(posedge clk);
        ready_mode = m;
        strict_gap = strict;
        @(negedge clk);
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(negedge clk);
        repeat (`CAM_HBLANK + 2) @(negedge clk);
    endtask

    task automatic start_test();
        test_errors0 = errors;
        test_rx0 = rx_count;
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (errors == test_errors0)
        begin
            $display("test %s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - test_errors0);
        end
    endtask

    // one output cycle as the next rising edge will see it
    task automatic watch_output();
        if (out_valid)
        begin
            if (after_eol && strict_gap && rx_count > test_rx0)
            begin
                check_value("hblank cycles", 32'(gap_cnt), `CAM_HBLANK);
            end
            after_eol = 1'b0;
            if (out_ready)
            begin
                check_value("lval", 32'(lval), 32'd1);
                check_value("fval", 32'(fval), 32'd1);
                if (exp_q.size() == 0)
                begin
                    report_error("a word came out that was never sent");
                end
                else
                begin
                    check_value("out_data", out_data, exp_q.pop_front());
                end
                rx_count++;
                if (frame_pos % `CAM_LINE_WORDS == `CAM_LINE_WORDS - 1)
                begin
                    after_eol = 1'b1;
                    gap_cnt = 0;
                end
                frame_pos = (frame_pos + 1) % FRAME_WORDS;
            end
        end
        else
        begin
            if (after_eol)
            begin
                gap_cnt++;
                check_value("lval", 32'(lval), 32'd0);
            end
            // between frames fval stays low
            if (frame_pos == 0)
            begin
                check_value("fval", 32'(fval), 32'd0);
            end
        end
    endtask

    initial
    begin : receiver
        seed = 72258;
        out_ready = 1'b0;
        rx_count = 0;
        frame_pos = 0;
        after_eol = 1'b0;
        gap_cnt = 0;
        forever
        begin
            @(negedge clk);
            case (ready_mode)
                READY_HIGH: out_ready = 1'b1;
                READY_LOW: out_ready = 1'b0;
                default: out_ready = ($random(seed) & 3) != 0;
            endcase
            if (rst_n)
            begin
                watch_output();
            end
        end
    end

    initial
    begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    initial
    begin : main
        int accepted;
        rst_n = 1'b0;
        sensor_valid = 1'b0;
        gain = '0;
        for (int c = 0; c < `CAM_CHANNELS; c++)
        begin
            samples[c] = '0;
        end
        ready_mode = READY_HIGH;
        strict_gap = 1'b0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        next_rec = 0;
        start_test();
        load_records();
        if (nrec == 0)
        begin
            $display("no test records could be read from tests/camera_tests.txt");
            $display(">>> FAIL");
            $finish;
        end
        else
        begin
            close_test("file_records");
            repeat (8) @(negedge clk);
            rst_n = 1'b1;

            start_test();
            check_value("sensor_ready", 32'(sensor_ready), 32'd1);
            check_value("out_valid", 32'(out_valid), 32'd0);
            check_value("lval", 32'(lval), 32'd0);
            check_value("fval", 32'(fval), 32'd0);
            close_test("reset_state");

            start_test();
            set_ready_mode(READY_HIGH, 1'b1);
            send_frames(STRICT_FRAMES);
            drain();
            close_test("frames_ready_high");

            // output blocked, the chain fills until credits run out
            start_test();
            set_ready_mode(READY_LOW, 1'b0);
            accepted = 0;
            while (sensor_ready && accepted < FRAME_WORDS)
            begin
                send_set();
                accepted++;
            end
            repeat (4) @(negedge clk);
            check_value("sensor_ready", 32'(sensor_ready), 32'd0);
            if (accepted != `CAM_FIFO_DEPTH && accepted != `CAM_FIFO_DEPTH + 1)
            begin
                report_error($sformatf("sensor_ready fell after %0d sets, not %0d or %0d",
                    accepted, `CAM_FIFO_DEPTH, `CAM_FIFO_DEPTH + 1));
            end
            set_ready_mode(READY_RANDOM, 1'b0);
            repeat (FRAME_WORDS - accepted) send_set();
            drain();
            close_test("stall_fill");

            start_test();
            send_frames(RANDOM_FRAMES);
            drain();
            close_test("random_ready");

            $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
                errors);
            if (errors == 0)
            begin
                $display(">>> PASS");
            end
            else
            begin
                $display(">>> FAIL");
            end
            $finish;
        end
    end

endmodule

// File: tests/camera_tests.txt
# gain sample0 sample1 sample2 sample3 expected_word, all fields in hex
# the expected word holds channel 0 in its low byte
0 3FF 000 200 155 558000FF
0 004 008 010 3FC FF040201
0 123 2AB 0F0 37E DF3CAA48
0 001 002 003 3FB FE000000
1 3FF 1FE 100 0AA 5580FFFF
1 200 002 155 2AA 55AA0100
1 123 0F1 301 07E 3F807891
1 010 020 040 080 40201008
2 3FF 100 0AB 2CD CDAB00FF
2 012 334 056 278 78563412
2 1EF 2BE 3AD 09C 9CADBEEF
2 000 201 302 103 03020100
3 3FF 3FE 3FD 3FC FCFDFEFF
3 1A5 25A 3C3 03C 3CC35AA5
3 211 122 233 344 44332211
3 080 181 282 383 83828180
